//--- hw/radio_fe_pkg.sv
// shared widths, settings/readback address map and ATR state codes
// imported by every front-end module of the two-radio core
package radio_fe_pkg;

   //////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////
   localparam int SAMPLE_W      = 32;  // I upper half, Q lower half
   localparam int SET_ADDR_W    = 8;
   localparam int SET_DATA_W    = 32;
   localparam int RB_DATA_W     = 64;
   localparam int GPIO_W        = 32;  // db gpio, fp gpio and misc words
   localparam int LED_W         = 3;
   localparam int FP_GPIO_WIDTH = 12;  // front-panel bits that exist
   localparam int ATR_W         = 2;
   localparam int IQ_CTRL_W     = 4;

   // ATR state is {tx_running, rx_running}
   localparam logic [ATR_W-1:0] ATR_IDLE = 2'd0;
   localparam logic [ATR_W-1:0] ATR_RX   = 2'd1;
   localparam logic [ATR_W-1:0] ATR_TX   = 2'd2;
   localparam logic [ATR_W-1:0] ATR_FDX  = 2'd3;

   //////////////////////////////////////////////////
   // settings addresses
   //////////////////////////////////////////////////
   localparam logic [SET_ADDR_W-1:0] REG_DB_IDLE  = 8'h00;
   localparam logic [SET_ADDR_W-1:0] REG_DB_RX    = 8'h01;
   localparam logic [SET_ADDR_W-1:0] REG_DB_TX    = 8'h02;
   localparam logic [SET_ADDR_W-1:0] REG_DB_FDX   = 8'h03;
   localparam logic [SET_ADDR_W-1:0] REG_DB_DDR   = 8'h04;
   localparam logic [SET_ADDR_W-1:0] REG_FP_IDLE  = 8'h08;
   localparam logic [SET_ADDR_W-1:0] REG_FP_RX    = 8'h09;
   localparam logic [SET_ADDR_W-1:0] REG_FP_TX    = 8'h0A;
   localparam logic [SET_ADDR_W-1:0] REG_FP_FDX   = 8'h0B;
   localparam logic [SET_ADDR_W-1:0] REG_FP_DDR   = 8'h0C;
   localparam logic [SET_ADDR_W-1:0] REG_LED_IDLE = 8'h10;
   localparam logic [SET_ADDR_W-1:0] REG_LED_RX   = 8'h11;
   localparam logic [SET_ADDR_W-1:0] REG_LED_TX   = 8'h12;
   localparam logic [SET_ADDR_W-1:0] REG_LED_FDX  = 8'h13;
   localparam logic [SET_ADDR_W-1:0] REG_MISC_OUT = 8'h18;
   localparam logic [SET_ADDR_W-1:0] REG_FP_SRC   = 8'h19;
   localparam logic [SET_ADDR_W-1:0] REG_IQ_CTRL  = 8'h1A;

   // bit positions inside REG_IQ_CTRL
   localparam int IQ_RX_SWAP = 0;
   localparam int IQ_TX_SWAP = 1;
   localparam int IQ_RX_NEGQ = 2;
   localparam int IQ_TX_NEGQ = 3;

   // readback addresses
   localparam logic [SET_ADDR_W-1:0] RB_GPIO_IN = 8'h00;  // {fp_in, db_in}
   localparam logic [SET_ADDR_W-1:0] RB_MISC_IN = 8'h01;  // {0, misc_in}
   localparam logic [SET_ADDR_W-1:0] RB_STATE   = 8'h02;  // iq_ctrl 7:4, state 1:0

endpackage

//--- hw/fe_settings_regs.sv
// settings register bank and readback mux for one radio front end
// writes land one cycle after the strobe, readback answers one cycle after request
`timescale 1ns/100ps

module fe_settings_regs (
   input  logic                                radio_clk,
   input  logic                                i_rst,
   input  logic                                i_set_stb,
   input  logic [radio_fe_pkg::SET_ADDR_W-1:0] i_set_addr,
   input  logic [radio_fe_pkg::SET_DATA_W-1:0] i_set_data,
   input  logic                                i_rb_stb,
   input  logic [radio_fe_pkg::SET_ADDR_W-1:0] i_rb_addr,
   input  logic [radio_fe_pkg::GPIO_W-1:0]     i_db_gpio_in,
   input  logic [radio_fe_pkg::GPIO_W-1:0]     i_fp_gpio_in,
   input  logic [radio_fe_pkg::GPIO_W-1:0]     i_misc_in,
   input  logic [radio_fe_pkg::ATR_W-1:0]      i_atr_state,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_db_atr [4],  // indexed by ATR code
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_db_ddr,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_fp_atr [4],
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_fp_ddr,
   output logic [radio_fe_pkg::LED_W-1:0]      o_led_atr [4],
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_misc_out,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_fp_src,
   output logic [radio_fe_pkg::IQ_CTRL_W-1:0]  o_iq_ctrl,
   output logic                                o_rb_stb,
   output logic [radio_fe_pkg::RB_DATA_W-1:0]  o_rb_data
);
   import radio_fe_pkg::*;

   //////////////////////////////////////////////////
   // settings write decode
   //////////////////////////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         for (int k = 0; k < 4; k++) begin
            o_db_atr[k]  <= '0;
            o_fp_atr[k]  <= '0;
            o_led_atr[k] <= '0;
         end
         o_db_ddr   <= '0;
         o_fp_ddr   <= '0;
         o_misc_out <= '0;
         o_fp_src   <= '0;
         o_iq_ctrl  <= '0;
      end else if (i_set_stb) begin
         case (i_set_addr)
            REG_DB_IDLE:  o_db_atr[ATR_IDLE]  <= i_set_data;
            REG_DB_RX:    o_db_atr[ATR_RX]    <= i_set_data;
            REG_DB_TX:    o_db_atr[ATR_TX]    <= i_set_data;
            REG_DB_FDX:   o_db_atr[ATR_FDX]   <= i_set_data;
            REG_DB_DDR:   o_db_ddr            <= i_set_data;
            REG_FP_IDLE:  o_fp_atr[ATR_IDLE]  <= i_set_data;
            REG_FP_RX:    o_fp_atr[ATR_RX]    <= i_set_data;
            REG_FP_TX:    o_fp_atr[ATR_TX]    <= i_set_data;
            REG_FP_FDX:   o_fp_atr[ATR_FDX]   <= i_set_data;
            REG_FP_DDR:   o_fp_ddr            <= i_set_data;
            REG_LED_IDLE: o_led_atr[ATR_IDLE] <= i_set_data[LED_W-1:0];
            REG_LED_RX:   o_led_atr[ATR_RX]   <= i_set_data[LED_W-1:0];
            REG_LED_TX:   o_led_atr[ATR_TX]   <= i_set_data[LED_W-1:0];
            REG_LED_FDX:  o_led_atr[ATR_FDX]  <= i_set_data[LED_W-1:0];
            REG_MISC_OUT: o_misc_out          <= i_set_data;
            REG_FP_SRC:   o_fp_src            <= i_set_data;
            REG_IQ_CTRL:  o_iq_ctrl           <= i_set_data[IQ_CTRL_W-1:0];
            default: ;                          // unmapped, dropped
         endcase
      end
   end

   //////////////////////////////////////////////////
   // readback, one result per cycle
   //////////////////////////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_rb_stb  <= 1'b0;
         o_rb_data <= '0;
      end else begin
         o_rb_stb <= i_rb_stb;
         case (i_rb_addr)
            RB_GPIO_IN: o_rb_data <= {i_fp_gpio_in, i_db_gpio_in};
            RB_MISC_IN: o_rb_data <= {{(RB_DATA_W-GPIO_W){1'b0}}, i_misc_in};
            RB_STATE:   o_rb_data <= {{(RB_DATA_W-8){1'b0}}, o_iq_ctrl, 2'b00, i_atr_state};
            default:    o_rb_data <= '0;
         endcase
      end
   end

endmodule

//--- hw/gpio_atr.sv
// ATR word select, registers the word that matches the current rx/tx state
// instantiated once per GPIO bank and once for the LEDs
`timescale 1ns/100ps

module gpio_atr #(
   parameter int WIDTH = 32
) (
   input  logic                           radio_clk,
   input  logic                           i_rst,
   input  logic [radio_fe_pkg::ATR_W-1:0] i_state,
   input  logic [WIDTH-1:0]               i_idle,
   input  logic [WIDTH-1:0]               i_rx,
   input  logic [WIDTH-1:0]               i_tx,
   input  logic [WIDTH-1:0]               i_fdx,
   output logic [WIDTH-1:0]               o_value
);
   import radio_fe_pkg::*;

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_value <= '0;
      end else begin
         case (i_state)
            ATR_IDLE: o_value <= i_idle;
            ATR_RX:   o_value <= i_rx;
            ATR_TX:   o_value <= i_tx;
            ATR_FDX:  o_value <= i_fdx;  // full duplex
         endcase
      end
   end

endmodule

//--- hw/iq_frontend.sv
// rx and tx sample paths, optional I/Q swap then saturating Q negation
// one sample per clock in each direction, one cycle of latency
`timescale 1ns/100ps

module iq_frontend (
   input  logic                               radio_clk,
   input  logic                               i_rst,
   input  logic [radio_fe_pkg::IQ_CTRL_W-1:0] i_iq_ctrl,
   input  logic [radio_fe_pkg::SAMPLE_W-1:0]  i_rx,
   input  logic [radio_fe_pkg::SAMPLE_W-1:0]  i_tx,
   output logic [radio_fe_pkg::SAMPLE_W-1:0]  o_rx,
   output logic [radio_fe_pkg::SAMPLE_W-1:0]  o_tx
);
   import radio_fe_pkg::*;

   localparam int HALF = SAMPLE_W / 2;

   function automatic logic [SAMPLE_W-1:0] iq_xform(
      input logic [SAMPLE_W-1:0] sample,
      input logic                swap,
      input logic                negq
   );
      logic [HALF-1:0] hi;
      logic [HALF-1:0] lo;
      hi = swap ? sample[HALF-1:0] : sample[SAMPLE_W-1:HALF];
      lo = swap ? sample[SAMPLE_W-1:HALF] : sample[HALF-1:0];
      if (negq) begin
         // most negative value has no positive twin, clip to max
         if (lo == {1'b1, {(HALF-1){1'b0}}})
            lo = {1'b0, {(HALF-1){1'b1}}};
         else
            lo = -lo;
      end
      return {hi, lo};
   endfunction

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_rx <= '0;
         o_tx <= '0;
      end else begin
         o_rx <= iq_xform(i_rx, i_iq_ctrl[IQ_RX_SWAP], i_iq_ctrl[IQ_RX_NEGQ]);
         o_tx <= iq_xform(i_tx, i_iq_ctrl[IQ_TX_SWAP], i_iq_ctrl[IQ_TX_NEGQ]);
      end
   end

endmodule

//--- hw/db_fe_channel.sv
// one radio's front end: settings bank, three ATR selectors and the IQ path
// ATR state comes straight from the radio core running flags
`timescale 1ns/100ps

module db_fe_channel (
   input  logic                                radio_clk,
   input  logic                                i_rst,
   input  logic                                i_set_stb,
   input  logic [radio_fe_pkg::SET_ADDR_W-1:0] i_set_addr,
   input  logic [radio_fe_pkg::SET_DATA_W-1:0] i_set_data,
   input  logic                                i_rb_stb,
   input  logic [radio_fe_pkg::SET_ADDR_W-1:0] i_rb_addr,
   input  logic                                i_rx_running,
   input  logic                                i_tx_running,
   input  logic [radio_fe_pkg::SAMPLE_W-1:0]   i_rx_adc,
   input  logic [radio_fe_pkg::SAMPLE_W-1:0]   i_tx_sample,
   input  logic [radio_fe_pkg::GPIO_W-1:0]     i_db_gpio_in,
   input  logic [radio_fe_pkg::GPIO_W-1:0]     i_fp_gpio_in,
   input  logic [radio_fe_pkg::GPIO_W-1:0]     i_misc_in,
   output logic                                o_rb_stb,
   output logic [radio_fe_pkg::RB_DATA_W-1:0]  o_rb_data,
   output logic [radio_fe_pkg::SAMPLE_W-1:0]   o_rx_sample,
   output logic [radio_fe_pkg::SAMPLE_W-1:0]   o_dac,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_db_gpio_out,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_db_gpio_ddr,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_fp_gpio_out,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_fp_gpio_ddr,
   output logic [radio_fe_pkg::LED_W-1:0]      o_led,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_misc_out,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_fp_src
);
   import radio_fe_pkg::*;

   logic [ATR_W-1:0]     atr_state;
   logic [GPIO_W-1:0]    db_atr [4];
   logic [GPIO_W-1:0]    fp_atr [4];
   logic [LED_W-1:0]     led_atr [4];
   logic [IQ_CTRL_W-1:0] iq_ctrl;

   assign atr_state = {i_tx_running, i_rx_running};  // matches ATR_* codes

   fe_settings_regs i_regs (
      .radio_clk    (radio_clk),
      .i_rst        (i_rst),
      .i_set_stb    (i_set_stb),
      .i_set_addr   (i_set_addr),
      .i_set_data   (i_set_data),
      .i_rb_stb     (i_rb_stb),
      .i_rb_addr    (i_rb_addr),
      .i_db_gpio_in (i_db_gpio_in),
      .i_fp_gpio_in (i_fp_gpio_in),
      .i_misc_in    (i_misc_in),
      .i_atr_state  (atr_state),
      .o_db_atr     (db_atr),
      .o_db_ddr     (o_db_gpio_ddr),
      .o_fp_atr     (fp_atr),
      .o_fp_ddr     (o_fp_gpio_ddr),
      .o_led_atr    (led_atr),
      .o_misc_out   (o_misc_out),
      .o_fp_src     (o_fp_src),
      .o_iq_ctrl    (iq_ctrl),
      .o_rb_stb     (o_rb_stb),
      .o_rb_data    (o_rb_data)
   );

   //////////////////////////////////////////////////
   // ATR selectors
   //////////////////////////////////////////////////
   gpio_atr #(.WIDTH(GPIO_W)) i_db_atr (
      .radio_clk (radio_clk), .i_rst (i_rst), .i_state (atr_state),
      .i_idle (db_atr[ATR_IDLE]), .i_rx (db_atr[ATR_RX]),
      .i_tx (db_atr[ATR_TX]), .i_fdx (db_atr[ATR_FDX]),
      .o_value (o_db_gpio_out)
   );

   gpio_atr #(.WIDTH(GPIO_W)) i_fp_atr (
      .radio_clk (radio_clk), .i_rst (i_rst), .i_state (atr_state),
      .i_idle (fp_atr[ATR_IDLE]), .i_rx (fp_atr[ATR_RX]),
      .i_tx (fp_atr[ATR_TX]), .i_fdx (fp_atr[ATR_FDX]),
      .o_value (o_fp_gpio_out)
   );

   gpio_atr #(.WIDTH(LED_W)) i_led_atr (
      .radio_clk (radio_clk), .i_rst (i_rst), .i_state (atr_state),
      .i_idle (led_atr[ATR_IDLE]), .i_rx (led_atr[ATR_RX]),
      .i_tx (led_atr[ATR_TX]), .i_fdx (led_atr[ATR_FDX]),
      .o_value (o_led)
   );

   iq_frontend i_iq (
      .radio_clk (radio_clk),
      .i_rst     (i_rst),
      .i_iq_ctrl (iq_ctrl),
      .i_rx      (i_rx_adc),
      .i_tx      (i_tx_sample),
      .o_rx      (o_rx_sample),
      .o_tx      (o_dac)
   );

endmodule

//--- hw/radio_io_map.sv
// shared I/O mapping between the two radio channels and the pins
// front-panel bits come from radio 0 or 1 per radio 0's source register
`timescale 1ns/100ps

module radio_io_map (
   input  logic                            radio_clk,
   input  logic                            i_rst,
   input  logic [radio_fe_pkg::GPIO_W-1:0] i_fp_src,
   input  logic [radio_fe_pkg::GPIO_W-1:0] i_fp_out0,
   input  logic [radio_fe_pkg::GPIO_W-1:0] i_fp_ddr0,
   input  logic [radio_fe_pkg::GPIO_W-1:0] i_fp_out1,
   input  logic [radio_fe_pkg::GPIO_W-1:0] i_fp_ddr1,
   input  logic [radio_fe_pkg::GPIO_W-1:0] i_misc_out0,
   input  logic [radio_fe_pkg::GPIO_W-1:0] i_misc_out1,
   input  logic [radio_fe_pkg::GPIO_W-1:0] i_misc_in0,
   input  logic [radio_fe_pkg::GPIO_W-1:0] i_misc_in1,
   output logic [radio_fe_pkg::GPIO_W-1:0] o_fp_gpio_out,
   output logic [radio_fe_pkg::GPIO_W-1:0] o_fp_gpio_ddr,
   output logic [radio_fe_pkg::GPIO_W-1:0] o_radio0_misc_out,
   output logic [radio_fe_pkg::GPIO_W-1:0] o_radio1_misc_out,
   output logic [radio_fe_pkg::GPIO_W-1:0] o_misc_in0,
   output logic [radio_fe_pkg::GPIO_W-1:0] o_misc_in1
);
   import radio_fe_pkg::*;

   logic [GPIO_W-1:0] fp_sel_out;
   logic [GPIO_W-1:0] fp_sel_ddr;

   // bit by bit source select, bits above FP_GPIO_WIDTH stay low
   always_comb begin
      fp_sel_out = '0;
      fp_sel_ddr = '0;
      for (int b = 0; b < FP_GPIO_WIDTH; b++) begin
         fp_sel_out[b] = i_fp_src[b] ? i_fp_out1[b] : i_fp_out0[b];
         fp_sel_ddr[b] = i_fp_src[b] ? i_fp_ddr1[b] : i_fp_ddr0[b];
      end
   end

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_fp_gpio_out     <= '0;
         o_fp_gpio_ddr     <= '0;
         o_radio0_misc_out <= '0;
         o_radio1_misc_out <= '0;
         o_misc_in0        <= '0;
         o_misc_in1        <= '0;
      end else begin
         o_fp_gpio_out     <= fp_sel_out;
         o_fp_gpio_ddr     <= fp_sel_ddr;
         o_radio0_misc_out <= i_misc_out0;
         o_radio1_misc_out <= i_misc_out1;
         o_misc_in0        <= i_misc_in0;  // pin side into readback
         o_misc_in1        <= i_misc_in1;
      end
   end

endmodule

//--- hw/radio_fe_top.sv
// top of the radio-side front end, two channels beside the shared I/O map
// settings and readback ports are driven by the radio core of each radio
`timescale 1ns/100ps

module radio_fe_top (
   input  logic                                radio_clk,
   input  logic                                i_rst,
   // radio 0
   input  logic                                i_set0_stb,
   input  logic [radio_fe_pkg::SET_ADDR_W-1:0] i_set0_addr,
   input  logic [radio_fe_pkg::SET_DATA_W-1:0] i_set0_data,
   input  logic                                i_rb0_stb,
   input  logic [radio_fe_pkg::SET_ADDR_W-1:0] i_rb0_addr,
   input  logic                                i_rx0_running,
   input  logic                                i_tx0_running,
   input  logic [radio_fe_pkg::SAMPLE_W-1:0]   i_rx0,
   input  logic [radio_fe_pkg::SAMPLE_W-1:0]   i_tx0,
   input  logic [radio_fe_pkg::GPIO_W-1:0]     i_db0_gpio_in,
   input  logic [radio_fe_pkg::GPIO_W-1:0]     i_radio0_misc_in,
   output logic                                o_rb0_stb,
   output logic [radio_fe_pkg::RB_DATA_W-1:0]  o_rb0_data,
   output logic [radio_fe_pkg::SAMPLE_W-1:0]   o_rx0,
   output logic [radio_fe_pkg::SAMPLE_W-1:0]   o_dac0,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_db0_gpio_out,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_db0_gpio_ddr,
   output logic [radio_fe_pkg::LED_W-1:0]      o_radio_led0,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_radio0_misc_out,
   // radio 1
   input  logic                                i_set1_stb,
   input  logic [radio_fe_pkg::SET_ADDR_W-1:0] i_set1_addr,
   input  logic [radio_fe_pkg::SET_DATA_W-1:0] i_set1_data,
   input  logic                                i_rb1_stb,
   input  logic [radio_fe_pkg::SET_ADDR_W-1:0] i_rb1_addr,
   input  logic                                i_rx1_running,
   input  logic                                i_tx1_running,
   input  logic [radio_fe_pkg::SAMPLE_W-1:0]   i_rx1,
   input  logic [radio_fe_pkg::SAMPLE_W-1:0]   i_tx1,
   input  logic [radio_fe_pkg::GPIO_W-1:0]     i_db1_gpio_in,
   input  logic [radio_fe_pkg::GPIO_W-1:0]     i_radio1_misc_in,
   output logic                                o_rb1_stb,
   output logic [radio_fe_pkg::RB_DATA_W-1:0]  o_rb1_data,
   output logic [radio_fe_pkg::SAMPLE_W-1:0]   o_rx1,
   output logic [radio_fe_pkg::SAMPLE_W-1:0]   o_dac1,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_db1_gpio_out,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_db1_gpio_ddr,
   output logic [radio_fe_pkg::LED_W-1:0]      o_radio_led1,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_radio1_misc_out,
   // shared front panel
   input  logic [radio_fe_pkg::GPIO_W-1:0]     i_fp_gpio_in,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_fp_gpio_out,
   output logic [radio_fe_pkg::GPIO_W-1:0]     o_fp_gpio_ddr
);
   import radio_fe_pkg::*;

   logic [GPIO_W-1:0] fp_out0, fp_ddr0, fp_out1, fp_ddr1;
   logic [GPIO_W-1:0] misc_out0, misc_out1, misc_in0, misc_in1;
   logic [GPIO_W-1:0] fp_src;  // radio 0 owns the front-panel mux

   db_fe_channel i_chan0 (
      .radio_clk (radio_clk), .i_rst (i_rst),
      .i_set_stb (i_set0_stb), .i_set_addr (i_set0_addr), .i_set_data (i_set0_data),
      .i_rb_stb (i_rb0_stb), .i_rb_addr (i_rb0_addr),
      .i_rx_running (i_rx0_running), .i_tx_running (i_tx0_running),
      .i_rx_adc (i_rx0), .i_tx_sample (i_tx0),
      .i_db_gpio_in (i_db0_gpio_in), .i_fp_gpio_in (i_fp_gpio_in), .i_misc_in (misc_in0),
      .o_rb_stb (o_rb0_stb), .o_rb_data (o_rb0_data),
      .o_rx_sample (o_rx0), .o_dac (o_dac0),
      .o_db_gpio_out (o_db0_gpio_out), .o_db_gpio_ddr (o_db0_gpio_ddr),
      .o_fp_gpio_out (fp_out0), .o_fp_gpio_ddr (fp_ddr0),
      .o_led (o_radio_led0), .o_misc_out (misc_out0), .o_fp_src (fp_src)
   );

   db_fe_channel i_chan1 (
      .radio_clk (radio_clk), .i_rst (i_rst),
      .i_set_stb (i_set1_stb), .i_set_addr (i_set1_addr), .i_set_data (i_set1_data),
      .i_rb_stb (i_rb1_stb), .i_rb_addr (i_rb1_addr),
      .i_rx_running (i_rx1_running), .i_tx_running (i_tx1_running),
      .i_rx_adc (i_rx1), .i_tx_sample (i_tx1),
      .i_db_gpio_in (i_db1_gpio_in), .i_fp_gpio_in (i_fp_gpio_in), .i_misc_in (misc_in1),
      .o_rb_stb (o_rb1_stb), .o_rb_data (o_rb1_data),
      .o_rx_sample (o_rx1), .o_dac (o_dac1),
      .o_db_gpio_out (o_db1_gpio_out), .o_db_gpio_ddr (o_db1_gpio_ddr),
      .o_fp_gpio_out (fp_out1), .o_fp_gpio_ddr (fp_ddr1),
      .o_led (o_radio_led1), .o_misc_out (misc_out1), .o_fp_src ()
   );

   radio_io_map i_io_map (
      .radio_clk         (radio_clk),
      .i_rst             (i_rst),
      .i_fp_src          (fp_src),
      .i_fp_out0         (fp_out0),
      .i_fp_ddr0         (fp_ddr0),
      .i_fp_out1         (fp_out1),
      .i_fp_ddr1         (fp_ddr1),
      .i_misc_out0       (misc_out0),
      .i_misc_out1       (misc_out1),
      .i_misc_in0        (i_radio0_misc_in),
      .i_misc_in1        (i_radio1_misc_in),
      .o_fp_gpio_out     (o_fp_gpio_out),
      .o_fp_gpio_ddr     (o_fp_gpio_ddr),
      .o_radio0_misc_out (o_radio0_misc_out),
      .o_radio1_misc_out (o_radio1_misc_out),
      .o_misc_in0        (misc_in0),
      .o_misc_in1        (misc_in1)
   );

endmodule

//--- testbench/tb_radio_fe.sv
// table-driven testbench for the two-radio front end
// each table row writes one register, sets running bits, then checks pins, samples, readback
`timescale 1ns/100ps

module tb_radio_fe;
   import radio_fe_pkg::*;

   typedef struct packed {
      logic       radio;
      logic [7:0] addr;
      logic [31:0] data;
      logic       tx;
      logic       rx;
      logic [7:0] rb_addr;
   } entry_t;

   logic radio_clk = 1'b0;
   logic i_rst;
   logic i_set0_stb, i_set1_stb, i_rb0_stb, i_rb1_stb;
   logic [SET_ADDR_W-1:0] i_set0_addr, i_set1_addr, i_rb0_addr, i_rb1_addr;
   logic [SET_DATA_W-1:0] i_set0_data, i_set1_data;
   logic i_rx0_running, i_tx0_running, i_rx1_running, i_tx1_running;
   logic [SAMPLE_W-1:0] i_rx0, i_tx0, i_rx1, i_tx1;
   logic [GPIO_W-1:0] i_db0_gpio_in, i_db1_gpio_in, i_radio0_misc_in, i_radio1_misc_in;
   logic [GPIO_W-1:0] i_fp_gpio_in;
   logic o_rb0_stb, o_rb1_stb;
   logic [RB_DATA_W-1:0] o_rb0_data, o_rb1_data;
   logic [SAMPLE_W-1:0] o_rx0, o_dac0, o_rx1, o_dac1;
   logic [GPIO_W-1:0] o_db0_gpio_out, o_db0_gpio_ddr, o_db1_gpio_out, o_db1_gpio_ddr;
   logic [LED_W-1:0] o_radio_led0, o_radio_led1;
   logic [GPIO_W-1:0] o_radio0_misc_out, o_radio1_misc_out, o_fp_gpio_out, o_fp_gpio_ddr;

   entry_t      stim[$];
   logic [31:0] regs [2][256];  // model register file per radio
   logic        run_rx [2];
   logic        run_tx [2];
   logic [31:0] lcg_state = 32'd26;
   int          value_errors = 0;
   int          other_errors = 0;
   int          n_entries = 0;

   radio_fe_top i_dut (.*);

   always #10 radio_clk = ~radio_clk;

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic add(input logic r, input logic [7:0] a, input logic [31:0] d,
                      input logic tx, input logic rx, input logic [7:0] rb);
      entry_t e;
      e = '{radio: r, addr: a, data: d, tx: tx, rx: rx, rb_addr: rb};
      stim.push_back(e);
   endtask

   task automatic wait_cycle();
      @(posedge radio_clk);
      #1;  // inputs move just after the edge
   endtask

   function automatic logic is_mapped(input logic [7:0] a);
      return (a <= 8'h04) || (a >= 8'h08 && a <= 8'h0C) ||
             (a >= 8'h10 && a <= 8'h13) || (a >= 8'h18 && a <= 8'h1A);
   endfunction

   function automatic int atr_idx(input int r, input int base);
      return base + 2 * int'(run_tx[r]) + int'(run_rx[r]);
   endfunction

   // each low bit comes from radio 1 when radio 0's source bit is set
   function automatic logic [31:0] pick_fp(input logic [31:0] w0, input logic [31:0] w1);
      logic [31:0] v;
      v = '0;
      for (int b = 0; b < FP_GPIO_WIDTH; b++)
         v[b] = regs[0][8'h19][b] ? w1[b] : w0[b];
      return v;
   endfunction

   function automatic logic [31:0] apply_iq(input logic [31:0] s, input logic swap,
                                            input logic negq);
      logic [15:0] i_part;
      logic [15:0] q_part;
      int          qv;
      i_part = swap ? s[15:0] : s[31:16];
      q_part = swap ? s[31:16] : s[15:0];
      if (negq) begin
         qv = -int'($signed(q_part));
         if (qv > 32767)
            qv = 32767;
         q_part = qv[15:0];
      end
      return {i_part, q_part};
   endfunction

   function automatic logic [63:0] rb_expect(input int r, input logic [7:0] a);
      case (a)
         RB_GPIO_IN: return {i_fp_gpio_in, (r == 1) ? i_db1_gpio_in : i_db0_gpio_in};
         RB_MISC_IN: return {32'h0, (r == 1) ? i_radio1_misc_in : i_radio0_misc_in};
         RB_STATE:   return {56'h0, regs[r][8'h1A][3:0], 2'b00, run_tx[r], run_rx[r]};
         default:    return 64'h0;
      endcase
   endfunction

   //////////////////////////////////////////////////
   // compare tasks
   //////////////////////////////////////////////////
   task automatic check_gpio(input string name, input logic [GPIO_W-1:0] exp,
                             input logic [GPIO_W-1:0] act);
      if (act !== exp) begin
         value_errors++;
         $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_led(input string name, input logic [LED_W-1:0] exp,
                            input logic [LED_W-1:0] act);
      if (act !== exp) begin
         value_errors++;
         $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_sample(input string name, input logic [SAMPLE_W-1:0] exp,
                               input logic [SAMPLE_W-1:0] act);
      if (act !== exp) begin
         value_errors++;
         $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_rb(input string name, input logic [RB_DATA_W-1:0] exp,
                           input logic [RB_DATA_W-1:0] act);
      if (act !== exp) begin
         value_errors++;
         $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_pins();
      check_gpio("o_db0_gpio_out", regs[0][atr_idx(0, 0)], o_db0_gpio_out);
      check_gpio("o_db1_gpio_out", regs[1][atr_idx(1, 0)], o_db1_gpio_out);
      check_gpio("o_db0_gpio_ddr", regs[0][8'h04], o_db0_gpio_ddr);
      check_gpio("o_db1_gpio_ddr", regs[1][8'h04], o_db1_gpio_ddr);
      check_led("o_radio_led0", regs[0][atr_idx(0, 16)][2:0], o_radio_led0);
      check_led("o_radio_led1", regs[1][atr_idx(1, 16)][2:0], o_radio_led1);
      check_gpio("o_radio0_misc_out", regs[0][8'h18], o_radio0_misc_out);
      check_gpio("o_radio1_misc_out", regs[1][8'h18], o_radio1_misc_out);
   endtask

   //////////////////////////////////////////////////
   // stimulus table
   //////////////////////////////////////////////////
   task automatic build_table();
      logic [31:0] flip;
      for (int r = 0; r < 2; r++) begin
         flip = (r == 1) ? 32'h0000_0FFF : 32'h0;  // radio 1 fp words invert the real bits
         add(1'(r), REG_DB_IDLE, 32'h1111_0001 + 32'(r), 1'b0, 1'b0, RB_STATE);
         add(1'(r), REG_DB_RX,   32'h2222_0002 + 32'(r), 1'b0, 1'b1, RB_STATE);
         add(1'(r), REG_DB_TX,   32'h3333_0003 + 32'(r), 1'b1, 1'b0, RB_STATE);
         add(1'(r), REG_DB_FDX,  32'h4444_0004 + 32'(r), 1'b1, 1'b1, RB_STATE);
         add(1'(r), REG_DB_DDR,  32'hFFFF_0000 >> r, 1'b0, 1'b0, RB_GPIO_IN);
         add(1'(r), REG_LED_IDLE, 32'hFFFF_FFF5, 1'b0, 1'b0, RB_MISC_IN);
         add(1'(r), REG_LED_RX,   32'h0000_0003, 1'b0, 1'b1, RB_MISC_IN);
         add(1'(r), REG_LED_TX,   32'h0000_0006, 1'b1, 1'b0, 8'h77);
         add(1'(r), REG_LED_FDX,  32'h0000_0007, 1'b1, 1'b1, 8'h03);
         // running changes alone, write goes to an unmapped address
         add(1'(r), 8'hFF, 32'hDEAD_BEEF, 1'b0, 1'b1, RB_STATE);
         add(1'(r), 8'h05, 32'hDEAD_BEEF, 1'b1, 1'b0, RB_STATE);
         add(1'(r), 8'h1B, 32'hDEAD_BEEF, 1'b0, 1'b0, RB_STATE);
         add(1'(r), 8'h14, 32'hDEAD_BEEF, 1'b1, 1'b1, RB_STATE);
         add(1'(r), REG_MISC_OUT, 32'hC0DE_0000 + 32'(r), 1'b1, 1'b1, RB_MISC_IN);
         add(1'(r), REG_FP_IDLE, 32'hFFFF_FA5A ^ flip, 1'b1, 1'b1, RB_GPIO_IN);
         add(1'(r), REG_FP_RX,   32'h1234_05A5 ^ flip, 1'b1, 1'b1, RB_GPIO_IN);
         add(1'(r), REG_FP_TX,   32'hF0F0_0F0F ^ flip, 1'b1, 1'b1, RB_GPIO_IN);
         add(1'(r), REG_FP_FDX,  32'hAAAA_0C33 ^ flip, 1'b1, 1'b1, RB_GPIO_IN);
         add(1'(r), REG_FP_DDR,  32'hFFFF_0F00 ^ flip, 1'b1, 1'b1, RB_GPIO_IN);
      end
      add(1'b0, REG_FP_SRC, 32'h0000_0FFF, 1'b1, 1'b1, RB_STATE);
      add(1'b1, REG_FP_SRC, 32'h0000_0000, 1'b1, 1'b1, RB_STATE);  // only radio 0 counts
      add(1'b1, 8'hFF, 32'h0, 1'b1, 1'b0, RB_STATE);
      add(1'b0, REG_FP_SRC, 32'hFFFF_FA5C, 1'b1, 1'b0, RB_STATE);
      add(1'b0, REG_FP_SRC, 32'h0000_0000, 1'b0, 1'b0, RB_STATE);
      for (int k = 0; k < 32; k++)
         add(1'(k / 16), REG_IQ_CTRL, 32'hFFFF_FFF0 | 32'(k % 16), 1'(k / 2), 1'(k / 4),
             RB_STATE);
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////
   initial begin
      entry_t      e;
      int          r;
      logic [31:0] exp_db1;
      logic [2:0]  exp_led1;
      logic [31:0] smp [4];
      logic [3:0]  iq0;
      logic [3:0]  iq1;
      i_rst = 1'b1;
      {i_set0_stb, i_set1_stb, i_rb0_stb, i_rb1_stb} = '0;
      {i_set0_addr, i_set1_addr, i_rb0_addr, i_rb1_addr} = '0;
      {i_set0_data, i_set1_data} = '0;
      {i_rx0_running, i_tx0_running, i_rx1_running, i_tx1_running} = '0;
      {i_rx0, i_tx0, i_rx1, i_tx1} = '0;
      i_db0_gpio_in    = lcg_next();
      i_db1_gpio_in    = lcg_next();
      i_radio0_misc_in = lcg_next();
      i_radio1_misc_in = lcg_next();
      i_fp_gpio_in     = lcg_next();
      for (int a = 0; a < 256; a++) begin
         regs[0][a] = '0;
         regs[1][a] = '0;
      end
      run_rx = '{1'b0, 1'b0};
      run_tx = '{1'b0, 1'b0};
      build_table();
      n_entries = stim.size();
      repeat (16) @(posedge radio_clk);
      #1 i_rst = 1'b0;
      wait_cycle();
      check_pins();  // everything zero out of reset
      check_gpio("o_fp_gpio_out", 32'h0, o_fp_gpio_out);
      check_gpio("o_fp_gpio_ddr", 32'h0, o_fp_gpio_ddr);
      check_sample("o_dac0", 32'h0, o_dac0);
      check_sample("o_dac1", 32'h0, o_dac1);

      foreach (stim[n]) begin
         e = stim[n];
         r = int'(e.radio);
         if (r == 0) begin
            {i_set0_stb, i_set0_addr, i_set0_data} = {1'b1, e.addr, e.data};
            {i_tx0_running, i_rx0_running} = {e.tx, e.rx};
         end else begin
            {i_set1_stb, i_set1_addr, i_set1_data} = {1'b1, e.addr, e.data};
            {i_tx1_running, i_rx1_running} = {e.tx, e.rx};
         end
         run_rx[r] = e.rx;
         run_tx[r] = e.tx;
         // first edge sees the new state but the old register words
         exp_db1  = regs[r][atr_idx(r, 0)];
         exp_led1 = regs[r][atr_idx(r, 16)][2:0];
         if (is_mapped(e.addr))
            regs[r][int'(e.addr)] = e.data;
         wait_cycle();
         i_set0_stb = 1'b0;
         i_set1_stb = 1'b0;
         check_gpio("o_db_gpio_out 1 cycle", exp_db1,
                    (r == 1) ? o_db1_gpio_out : o_db0_gpio_out);
         check_led("o_radio_led 1 cycle", exp_led1, (r == 1) ? o_radio_led1 : o_radio_led0);
         wait_cycle();
         check_pins();
         if (o_rb0_stb !== 1'b0 || o_rb1_stb !== 1'b0) begin
            other_errors++;
            $display("readback strobe high with no request pending at %0t", $time);
         end
         wait_cycle();
         check_gpio("o_fp_gpio_out", pick_fp(regs[0][atr_idx(0, 8)], regs[1][atr_idx(1, 8)]),
                    o_fp_gpio_out);
         check_gpio("o_fp_gpio_ddr", pick_fp(regs[0][8'h0C], regs[1][8'h0C]), o_fp_gpio_ddr);

         // samples, second pass exercises the most negative Q
         iq0 = regs[0][8'h1A][3:0];
         iq1 = regs[1][8'h1A][3:0];
         for (int s = 0; s < 2; s++) begin
            for (int j = 0; j < 4; j++)
               smp[j] = (s == 1) ? (32'h8000_8000 ^ (32'h0001_0000 * 32'(j))) : lcg_next();
            {i_rx0, i_tx0, i_rx1, i_tx1} = {smp[0], smp[1], smp[2], smp[3]};
            wait_cycle();
            check_sample("o_rx0", apply_iq(smp[0], iq0[IQ_RX_SWAP], iq0[IQ_RX_NEGQ]), o_rx0);
            check_sample("o_dac0", apply_iq(smp[1], iq0[IQ_TX_SWAP], iq0[IQ_TX_NEGQ]), o_dac0);
            check_sample("o_rx1", apply_iq(smp[2], iq1[IQ_RX_SWAP], iq1[IQ_RX_NEGQ]), o_rx1);
            check_sample("o_dac1", apply_iq(smp[3], iq1[IQ_TX_SWAP], iq1[IQ_TX_NEGQ]), o_dac1);
         end

         if (r == 0)
            {i_rb0_stb, i_rb0_addr} = {1'b1, e.rb_addr};
         else
            {i_rb1_stb, i_rb1_addr} = {1'b1, e.rb_addr};
         wait_cycle();
         i_rb0_stb = 1'b0;
         i_rb1_stb = 1'b0;
         if (((r == 1) ? o_rb1_stb : o_rb0_stb) !== 1'b1) begin
            other_errors++;
            $display("readback strobe missing on radio %0d at %0t", r, $time);
         end
         check_rb("o_rb_data", rb_expect(r, e.rb_addr), (r == 1) ? o_rb1_data : o_rb0_data);
      end

      $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // watchdog, sized from the table length
   initial begin
      wait (n_entries > 0);
      #(n_entries * 8 * 20 + 2000);
      $display("timeout, the test sequence did not finish in time");
      $display("Finished with errors");
      $finish;
   end

endmodule

//--- vlog.f
hw/radio_fe_pkg.sv
hw/fe_settings_regs.sv
hw/gpio_atr.sv
hw/iq_frontend.sv
hw/db_fe_channel.sv
hw/radio_io_map.sv
hw/radio_fe_top.sv
testbench/tb_radio_fe.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_radio_fe
FLIST     := vlog.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
